//--- design/stat_consts.svh
`ifndef STAT_CONSTS_SVH
`define STAT_CONSTS_SVH

// byte lanes on the monitored 64-bit link
`define STAT_KEEP_W 8

// window tag carried at the head of each report
`define STAT_TAG_W 16

// width of the tick, byte and frame counters
`define STAT_CNT_W 32

// report bytes as tag 2 + ticks 4 + bytes 4 + frames 4
`define STAT_REPORT_LEN 14

// pointer over the report bytes 0 to 13
`define STAT_PTR_W 4

`endif

//--- design/stat_pkg.sv
`default_nettype none

package stat_pkg;

    // report serializer states
    typedef enum logic {
        RPT_IDLE = 1'b0,
        RPT_SEND = 1'b1
    } report_state_t;

endpackage

`default_nettype wire

//--- design/stat_ifs.sv
`default_nettype none
`timescale 1ns/100ps

`include "stat_consts.svh"

// passive tap on the monitored AXI-Stream link
interface link_tap_if;
    logic [`STAT_KEEP_W-1:0] keep;
    logic                    valid;
    logic                    ready;
    logic                    last;

    // the monitor only observes
    modport monitor (
        input keep,
        input valid,
        input ready,
        input last
    );

    modport source (
        output keep,
        output valid,
        output ready,
        output last
    );
endinterface

// 8-bit report stream with valid, ready and last
interface byte_stream_if;
    logic [7:0] data;
    logic       valid;
    logic       ready;
    logic       last;

    modport source (
        output data,
        output valid,
        output last,
        input  ready
    );

    modport sink (
        input  data,
        input  valid,
        input  last,
        output ready
    );
endinterface

`default_nettype wire

//--- design/stat_collector.sv
`default_nettype none
`timescale 1ns/100ps

`include "stat_consts.svh"

module stat_collector (
    input  logic                   clk,
    input  logic                   rst,
    link_tap_if.monitor            tap,
    input  logic                   capture,
    output logic [`STAT_CNT_W-1:0] snap_ticks,
    output logic [`STAT_CNT_W-1:0] snap_bytes,
    output logic [`STAT_CNT_W-1:0] snap_frames
);

    logic [`STAT_CNT_W-1:0] tick_cnt;
    logic [`STAT_CNT_W-1:0] byte_cnt;
    logic [`STAT_CNT_W-1:0] frame_cnt;
    logic                   in_frame;

    logic [$clog2(`STAT_KEEP_W+1)-1:0] keep_cnt;
    logic                              beat;
    logic                              frame_start;

    logic [`STAT_CNT_W-1:0] tick_base;
    logic [`STAT_CNT_W-1:0] byte_base;
    logic [`STAT_CNT_W-1:0] frame_base;

    assign beat        = tap.valid && tap.ready;
    assign frame_start = beat && !in_frame;

    // number of lanes carrying a byte on this beat
    always_comb begin
        keep_cnt = '0;
        for (int i = 0; i < `STAT_KEEP_W; i++) begin
            keep_cnt = keep_cnt + {{($bits(keep_cnt)-1){1'b0}}, tap.keep[i]};
        end
    end

    // a capture restarts the window and this cycle still counts in the new one
    assign tick_base  = capture ? '0 : tick_cnt;
    assign byte_base  = capture ? '0 : byte_cnt;
    assign frame_base = capture ? '0 : frame_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tick_cnt  <= '0;
            byte_cnt  <= '0;
            frame_cnt <= '0;
            in_frame  <= 1'b0;
        end else begin
            tick_cnt <= tick_base + `STAT_CNT_W'(`STAT_KEEP_W);
            if (beat) begin
                byte_cnt <= byte_base + `STAT_CNT_W'(keep_cnt);
                // single-beat frames leave in_frame clear
                in_frame <= !tap.last;
            end else begin
                byte_cnt <= byte_base;
            end
            if (frame_start) begin
                frame_cnt <= frame_base + `STAT_CNT_W'(1);
            end else begin
                frame_cnt <= frame_base;
            end
        end
    end

    // closed window values that are valid the cycle after capture
    always_ff @(posedge clk) begin
        if (capture) begin
            snap_ticks  <= tick_cnt;
            snap_bytes  <= byte_cnt;
            snap_frames <= frame_cnt;
        end
    end

endmodule

`default_nettype wire

//--- design/stat_report_ser.sv
`default_nettype none
`timescale 1ns/100ps

`include "stat_consts.svh"

module stat_report_ser import stat_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   trigger,
    input  logic [`STAT_TAG_W-1:0] tag,
    input  logic [`STAT_CNT_W-1:0] snap_ticks,
    input  logic [`STAT_CNT_W-1:0] snap_bytes,
    input  logic [`STAT_CNT_W-1:0] snap_frames,
    output logic                   capture,
    output logic                   busy,
    byte_stream_if.source          rpt
);

    report_state_t state;
    report_state_t state_next;

    logic [`STAT_PTR_W-1:0] ptr;
    logic [`STAT_PTR_W-1:0] ptr_next;
    logic [`STAT_TAG_W-1:0] tag_q;

    // report image with the first byte in the top bits
    logic [`STAT_REPORT_LEN*8-1:0] record;

    assign record = {tag_q, snap_ticks, snap_bytes, snap_frames};

    // triggers while sending are dropped here
    assign capture = (state == RPT_IDLE) && trigger;
    assign busy    = (state == RPT_SEND);

    always_comb begin
        state_next = state;
        ptr_next   = ptr;
        rpt.valid  = 1'b0;
        rpt.last   = 1'b0;
        // byte 0 can leave in the trigger cycle, before tag_q is loaded
        if (state == RPT_IDLE) begin
            rpt.data = tag[`STAT_TAG_W-1 -: 8];
        end else begin
            rpt.data = record[8*(`STAT_REPORT_LEN-1-int'(ptr)) +: 8];
        end

        case (state)
            RPT_IDLE: begin
                if (trigger) begin
                    state_next = RPT_SEND;
                    ptr_next   = '0;
                    if (rpt.ready) begin
                        rpt.valid = 1'b1;
                        ptr_next  = `STAT_PTR_W'(1);
                    end
                end
            end
            RPT_SEND: begin
                if (rpt.ready) begin
                    rpt.valid = 1'b1;
                    ptr_next  = ptr + `STAT_PTR_W'(1);
                    if (ptr == `STAT_PTR_W'(`STAT_REPORT_LEN-1)) begin
                        rpt.last   = 1'b1;
                        state_next = RPT_IDLE;
                        ptr_next   = '0;
                    end
                end
            end
            default: begin
                state_next = RPT_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= RPT_IDLE;
            ptr   <= '0;
        end else begin
            state <= state_next;
            ptr   <= ptr_next;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            tag_q <= tag;
        end
    end

endmodule

`default_nettype wire

//--- design/byte_skid_buffer.sv
`default_nettype none
`timescale 1ns/100ps

module byte_skid_buffer (
    input  logic        clk,
    input  logic        rst,
    byte_stream_if.sink in_s,
    output logic [7:0]  out_data,
    output logic        out_valid,
    output logic        out_last,
    input  logic        out_ready
);

    logic [7:0] temp_data;
    logic       temp_valid;
    logic       temp_last;

    logic ready_early;
    logic load_out_in;
    logic load_temp;
    logic load_out_temp;

    // accept next cycle if the output drains, both slots are empty,
    // or temp is empty and nothing arrives now
    assign ready_early = out_ready
                       || (!temp_valid && !out_valid)
                       || (!temp_valid && !in_s.valid);

    assign load_out_in   = in_s.ready && (out_ready || !out_valid);
    assign load_temp     = in_s.ready && !out_ready && out_valid;
    assign load_out_temp = !in_s.ready && out_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_s.ready <= 1'b0;
            out_valid  <= 1'b0;
            out_last   <= 1'b0;
            temp_valid <= 1'b0;
            temp_last  <= 1'b0;
        end else begin
            in_s.ready <= ready_early;
            if (load_out_in) begin
                out_valid <= in_s.valid;
                out_last  <= in_s.last;
            end else if (load_temp) begin
                temp_valid <= in_s.valid;
                temp_last  <= in_s.last;
            end else if (load_out_temp) begin
                out_valid  <= temp_valid;
                out_last   <= temp_last;
                temp_valid <= 1'b0;
                temp_last  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_out_in) begin
            out_data <= in_s.data;
        end else if (load_temp) begin
            temp_data <= in_s.data;
        end else if (load_out_temp) begin
            out_data <= temp_data;
        end
    end

endmodule

`default_nettype wire

//--- design/stat_monitor_top.sv
`default_nettype none
`timescale 1ns/100ps

`include "stat_consts.svh"

module stat_monitor_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`STAT_KEEP_W-1:0] mon_keep,
    input  logic                    mon_valid,
    input  logic                    mon_ready,
    input  logic                    mon_last,
    input  logic [`STAT_TAG_W-1:0]  tag,
    input  logic                    trigger,
    output logic [7:0]              out_data,
    output logic                    out_valid,
    output logic                    out_last,
    input  logic                    out_ready,
    output logic                    busy
);

    link_tap_if    tap_if ();
    byte_stream_if rpt_if ();

    logic                   capture;
    logic [`STAT_CNT_W-1:0] snap_ticks;
    logic [`STAT_CNT_W-1:0] snap_bytes;
    logic [`STAT_CNT_W-1:0] snap_frames;

    assign tap_if.keep  = mon_keep;
    assign tap_if.valid = mon_valid;
    assign tap_if.ready = mon_ready;
    assign tap_if.last  = mon_last;

    stat_collector u_collector (
        .clk         (clk),
        .rst         (rst),
        .tap         (tap_if.monitor),
        .capture     (capture),
        .snap_ticks  (snap_ticks),
        .snap_bytes  (snap_bytes),
        .snap_frames (snap_frames)
    );

    stat_report_ser u_report_ser (
        .clk         (clk),
        .rst         (rst),
        .trigger     (trigger),
        .tag         (tag),
        .snap_ticks  (snap_ticks),
        .snap_bytes  (snap_bytes),
        .snap_frames (snap_frames),
        .capture     (capture),
        .busy        (busy),
        .rpt         (rpt_if.source)
    );

    byte_skid_buffer u_skid (
        .clk       (clk),
        .rst       (rst),
        .in_s      (rpt_if.sink),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

//--- bench/stat_monitor_chk.sv
`default_nettype none
`timescale 1ns/100ps

module stat_monitor_chk (
    input logic       clk,
    input logic       rst,
    input logic [7:0] out_data,
    input logic       out_valid,
    input logic       out_last,
    input logic       out_ready,
    input logic       busy
);

    // a stalled report byte holds until it is taken
    hold_stalled: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
        else $error("report byte changed while stalled");

    quiet_after_reset: assert property (@(posedge clk)
        (rst || $past(rst) || $past(rst, 2)) |-> !busy)
        else $error("busy high within two cycles of reset");

    // only a new report may keep out_valid up after the last byte
    end_of_report: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready && out_last |=> !out_valid || busy)
        else $error("out_valid held after the last byte with no report running");

endmodule

bind stat_monitor_top stat_monitor_chk chk0 (
    .clk       (clk),
    .rst       (rst),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_last  (out_last),
    .out_ready (out_ready),
    .busy      (busy)
);

`default_nettype wire

//--- bench/stat_monitor_tb.sv
`default_nettype none
`timescale 1ns/100ps

`include "stat_consts.svh"

module stat_monitor_tb;

    logic                    clk;
    logic                    rst;
    logic [`STAT_KEEP_W-1:0] mon_keep;
    logic                    mon_valid;
    logic                    mon_ready;
    logic                    mon_last;
    logic [`STAT_TAG_W-1:0]  tag;
    logic                    trigger;
    logic [7:0]              out_data;
    logic                    out_valid;
    logic                    out_last;
    logic                    out_ready;
    logic                    busy;

    // record layout with out_ready mode in 29:28, then trigger, valid, ready, last,
    // keep in 23:16 and tag in 15:0
    logic [29:0] stim_rec[$];
    int          stim_reps[$];
    logic [7:0]  exp_q[$];

    int err_count   = 0;
    int rx_count    = 0;
    int take_run    = 0;
    int cycle_count = 0;
    int cycle_limit = 0;
    int total_cycles = 0;
    int n_reports   = 0;

    stat_monitor_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .mon_keep  (mon_keep),
        .mon_valid (mon_valid),
        .mon_ready (mon_ready),
        .mon_last  (mon_last),
        .tag       (tag),
        .trigger   (trigger),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_ready (out_ready),
        .busy      (busy)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic load_golden();
        int          fd;
        int          reps;
        logic [31:0] f_trig, f_tag, f_keep, f_valid, f_ready, f_last, f_ordy;
        string       line;
        fd = $fopen("bench/stat_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/stat_golden.txt");
            err_count++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] == "S") begin
                void'($sscanf(line, "S %d %h %h %h %h %h %h %h", reps, f_trig, f_tag,
                              f_keep, f_valid, f_ready, f_last, f_ordy));
                stim_reps.push_back(reps);
                stim_rec.push_back({f_ordy[1:0], f_trig[0], f_valid[0], f_ready[0],
                                    f_last[0], f_keep[7:0], f_tag[15:0]});
                total_cycles += reps;
            end else if (line.len() > 1 && line[0] == "E") begin
                for (int i = 0; i < `STAT_REPORT_LEN; i++) begin
                    exp_q.push_back(8'(line.substr(2 + 3*i, 3 + 3*i).atohex()));
                end
                n_reports++;
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_record(input logic [29:0] rec);
        tag       <= rec[15:0];
        mon_keep  <= rec[23:16];
        mon_last  <= rec[24];
        mon_ready <= rec[25];
        mon_valid <= rec[26];
        trigger   <= rec[27];
        // mode 2 toggles out_ready at random
        if (rec[29:28] == 2'd2) begin
            out_ready <= ($urandom & 1) == 1;
        end else begin
            out_ready <= rec[28];
        end
    endtask

    // outputs are sampled between edges since a byte moves on the next rising edge
    always @(negedge clk) begin
        if (!rst && out_valid && out_ready) begin
            if (rx_count < exp_q.size()) begin
                assert (out_data == exp_q[rx_count]) else begin
                    $display("ERR out_data: expected 0x%02h, got 0x%02h at byte %0d",
                             exp_q[rx_count], out_data, rx_count);
                    err_count++;
                end
                assert (out_last == (rx_count % `STAT_REPORT_LEN == `STAT_REPORT_LEN - 1))
                else begin
                    $display("ERR out_last: expected 0x%0h, got 0x%0h at byte %0d",
                             rx_count % `STAT_REPORT_LEN == `STAT_REPORT_LEN - 1,
                             out_last, rx_count);
                    err_count++;
                end
                // bytes 0 to 11 leave while the last byte is still in the serializer
                if (rx_count % `STAT_REPORT_LEN < `STAT_REPORT_LEN - 2) begin
                    assert (busy) else begin
                        $display("ERR busy: expected 0x1, got 0x%0h at byte %0d",
                                 busy, rx_count);
                        err_count++;
                    end
                end else if (rx_count % `STAT_REPORT_LEN == `STAT_REPORT_LEN - 1
                             && take_run >= 2) begin
                    // the last byte entered the skid buffer on the previous edge
                    assert (!busy) else begin
                        $display("ERR busy: expected 0x0, got 0x%0h at byte %0d",
                                 busy, rx_count);
                        err_count++;
                    end
                end
            end else begin
                $display("report byte 0x%02h arrived beyond the expected list", out_data);
                err_count++;
            end
            rx_count++;
            take_run++;
        end else begin
            take_run = 0;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: reports not complete after %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h1735));
        rst       = 1'b1;
        trigger   = 1'b0;
        tag       = '0;
        mon_keep  = '0;
        mon_valid = 1'b0;
        mon_ready = 1'b0;
        mon_last  = 1'b0;
        out_ready = 1'b0;
        load_golden();
        cycle_limit = total_cycles + `STAT_REPORT_LEN * n_reports + 50;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        foreach (stim_reps[i]) begin
            repeat (stim_reps[i]) begin
                drive_record(stim_rec[i]);
                @(posedge clk);
            end
        end
        // hold the link quiet and drain what is left
        drive_record({2'd1, 28'd0});
        while (rx_count < exp_q.size()) @(posedge clk);
        repeat (4) @(posedge clk);
        assert (!busy && !out_valid) else begin
            $display("busy or out_valid still high after the last report");
            err_count++;
        end
        $display("summary: %0d report bytes checked, %0d errors", rx_count, err_count);
        if (err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/stat_golden.txt
# S cycles trigger tag keep valid ready last out_ready (2 = random), held for that many cycles
# E the 14 expected report bytes in order: tag, ticks, bytes, frames
S 20 0 0000 00 0 0 0 1
S 1 1 a101 00 0 0 0 1
S 2 0 0000 ff 1 1 0 1
S 1 0 0000 0f 1 0 0 1
S 1 0 0000 0f 1 1 1 1
S 1 0 0000 ff 0 1 1 1
S 3 0 0000 01 1 1 1 1
S 1 0 0000 3c 1 1 0 1
S 1 0 0000 81 1 1 1 1
S 9 0 0000 00 0 0 0 1
S 1 1 b202 ff 1 1 0 1
S 1 0 0000 ff 1 1 1 1
S 1 0 0000 00 0 0 0 1
S 1 1 dead 00 0 0 0 1
S 26 0 0000 00 0 0 0 1
S 1 1 c303 00 0 0 0 1
S 30 0 0000 07 1 1 0 2
S 1 0 0000 07 1 1 1 2
S 20 0 0000 00 0 0 0 1
S 1 1 d404 00 0 0 0 2
S 40 0 0000 00 0 0 0 2
S 20 0 0000 00 0 0 0 1
S 1 1 e505 00 0 0 0 1
S 13 0 0000 ff 1 1 1 1
S 1 1 f606 00 0 0 0 1
S 12 0 0000 00 0 0 0 1
E a1 01 00 00 00 a0 00 00 00 00 00 00 00 00
E b2 02 00 00 00 a0 00 00 00 1d 00 00 00 05
E c3 03 00 00 00 f0 00 00 00 10 00 00 00 01
E d4 04 00 00 01 a0 00 00 00 5d 00 00 00 01
E e5 05 00 00 01 e8 00 00 00 00 00 00 00 00
E f6 06 00 00 00 70 00 00 00 68 00 00 00 0d

//--- project.f
+incdir+design
design/stat_pkg.sv
design/stat_ifs.sv
design/stat_collector.sv
design/stat_report_ser.sv
design/byte_skid_buffer.sv
design/stat_monitor_top.sv
bench/stat_monitor_chk.sv
bench/stat_monitor_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= stat_monitor_tb
RTL_TOP   ?= stat_monitor_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --assert --timing
SOURCES   := $(wildcard design/*.sv design/*.svh bench/*.sv bench/*.txt)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
